/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP       := tb_icache
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/icache_assertions.sv */
`timescale 1ns/100ps

module icache_assertions import icache_pkg::*; (
  input logic        clk,
  input logic        rstn,
  input logic        fetch_arvalid,
  input logic        fetch_arready,
  input logic        fetch_rvalid,
  input logic        fetch_rready,
  input beat_t       fetch_rdata,
  input logic        mem_arvalid,
  input logic        mem_arready,
  input addr_t       mem_araddr,
  input logic        mem_rready,
  input logic [31:0] hit_count,
  input logic [31:0] miss_count
);

  logic  failed = 1'b0;  // watched by the testbench top
  beat_t prev_rdata;
  addr_t prev_araddr;

  always_ff @(posedge clk) begin
    prev_rdata  <= fetch_rdata;
    prev_araddr <= mem_araddr;
  end

  a_reset_ready: assert property (@(posedge clk) !rstn |=> fetch_arready)
    else begin
      failed = 1'b1;
      $error("Error: %0t fetch_arready expected 1 actual %b", $time, $sampled(fetch_arready));
    end

  a_reset_quiet: assert property (@(posedge clk) !rstn |=> !fetch_rvalid && !mem_arvalid)
    else begin
      failed = 1'b1;
      $error("Error: %0t fetch_rvalid/mem_arvalid expected 0/0 actual %b/%b",
             $time, $sampled(fetch_rvalid), $sampled(mem_arvalid));
    end

  a_reset_counts: assert property (@(posedge clk)
      !rstn |=> (hit_count == 32'd0) && (miss_count == 32'd0))
    else begin
      failed = 1'b1;
      $error("Error: %0t hit_count/miss_count expected 0/0 actual %0d/%0d",
             $time, $sampled(hit_count), $sampled(miss_count));
    end

  a_araddr_aligned: assert property (@(posedge clk) disable iff (!rstn)
      mem_arvalid |-> (mem_araddr[2:0] == 3'b000))
    else begin
      failed = 1'b1;
      $error("Error: %0t mem_araddr[2:0] expected 0 actual %0d",
             $time, $sampled(mem_araddr[2:0]));
    end

  // read data is always accepted
  a_mem_rready: assert property (@(posedge clk) disable iff (!rstn) mem_rready)
    else begin
      failed = 1'b1;
      $error("Error: %0t mem_rready expected 1 actual %b", $time, $sampled(mem_rready));
    end

  // stalled memory address
  a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
      mem_arvalid && !mem_arready |=> mem_arvalid && (mem_araddr == prev_araddr))
    else begin
      failed = 1'b1;
      $error("Error: %0t mem_araddr expected %h actual %h (mem_arvalid %b)",
             $time, $sampled(prev_araddr), $sampled(mem_araddr), $sampled(mem_arvalid));
    end

  a_resp_hold: assert property (@(posedge clk) disable iff (!rstn)
      fetch_rvalid && !fetch_rready |=> fetch_rvalid && (fetch_rdata == prev_rdata))
    else begin
      failed = 1'b1;
      $error("Error: %0t fetch_rdata expected %h actual %h (fetch_rvalid %b)",
             $time, $sampled(prev_rdata), $sampled(fetch_rdata), $sampled(fetch_rvalid));
    end

  a_one_in_flight: assert property (@(posedge clk) disable iff (!rstn)
      (fetch_arvalid && fetch_arready) ||
      (!fetch_arready && !(fetch_rvalid && fetch_rready)) |=> !fetch_arready)
    else begin
      failed = 1'b1;
      $error("Error: %0t fetch_arready expected 0 actual %b", $time, $sampled(fetch_arready));
    end

endmodule

bind icache_top icache_assertions u_checks (
  .clk           (clk),
  .rstn          (rstn),
  .fetch_arvalid (fetch_arvalid),
  .fetch_arready (fetch_arready),
  .fetch_rvalid  (fetch_rvalid),
  .fetch_rready  (fetch_rready),
  .fetch_rdata   (fetch_rdata),
  .mem_arvalid   (mem_arvalid),
  .mem_arready   (mem_arready),
  .mem_araddr    (mem_araddr),
  .mem_rready    (mem_rready),
  .hit_count     (hit_count),
  .miss_count    (miss_count)
);

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

/* bench/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache import icache_pkg::*; ;

  localparam int NUM_BANKS        = 2;
  localparam int INDEX_W          = 3;
  localparam int BANK_W           = $clog2(NUM_BANKS);
  localparam int TAG_LSB          = 2 + BANK_W + INDEX_W;
  localparam int CLK_PERIOD       = 8;
  localparam int CYCLES_PER_FETCH = 200;
  localparam int RANDOM_FETCHES   = 80;

  logic        clk;
  logic        rstn;
  logic        fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
  addr_t       fetch_araddr;
  beat_t       fetch_rdata;
  logic        mem_arvalid, mem_arready, mem_rvalid, mem_rready;
  addr_t       mem_araddr;
  beat_t       mem_rdata;
  logic [31:0] hit_count, miss_count;

  addr_t       fetch_q [$];
  logic        queue_ready = 1'b0;
  int unsigned mem_requests = 0;
  logic                  model_valid [NUM_BANKS][1 << INDEX_W];
  logic [31:TAG_LSB]     model_tag   [NUM_BANKS][1 << INDEX_W];

  tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

  icache_top #(.NUM_BANKS(NUM_BANKS), .INDEX_W(INDEX_W)) uut (.*);

  function automatic word_t mem_word(addr_t a);
    return a ^ 32'h5A5A_0000;
  endfunction

  function automatic logic in_cached_region(addr_t a);
    return a[31:28] >= 4'd3;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // drops arready a few cycles, answers 1 to 5 cycles after the address
  initial begin : memory_model
    addr_t       line;
    int unsigned delay;
    mem_arready = 1'b0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    wait (rstn);
    forever begin
      @(posedge clk);
      #1;
      if (mem_arvalid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk);
        #1;
        line        = mem_araddr;
        mem_arready = 1'b1;
        @(posedge clk);
        #1;
        mem_arready = 1'b0;
        mem_requests++;
        delay = $urandom_range(5, 1);
        repeat (delay - 1) @(posedge clk);
        #1;
        mem_rvalid = 1'b1;
        mem_rdata  = {mem_word(line | 32'd4), mem_word(line & ~32'd4)};
        @(posedge clk);
        #1;
        mem_rvalid = 1'b0;
      end
    end
  end

  task automatic run_fetch(input addr_t a);
    logic [BANK_W-1:0]  bank;
    logic [INDEX_W-1:0] idx;
    logic               expect_hit, take;
    int unsigned        cycles, exp_hits, exp_misses, exp_mem;
    word_t              got;
    bank       = a[2 +: BANK_W];
    idx        = a[2 + BANK_W +: INDEX_W];
    expect_hit = in_cached_region(a) && model_valid[bank][idx] &&
                 (model_tag[bank][idx] == a[31:TAG_LSB]);
    exp_hits   = hit_count + (expect_hit ? 1 : 0);
    exp_misses = miss_count + (expect_hit ? 0 : 1);
    exp_mem    = mem_requests + (expect_hit ? 0 : 1);
    fetch_arvalid = 1'b1;
    fetch_araddr  = a;
    @(posedge clk);
    #1;
    fetch_arvalid = 1'b0;
    cycles        = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!fetch_rvalid);
    assert (!expect_hit || cycles == 1)
      else stop_with_failure($sformatf("Error: %0t fetch_rvalid latency expected 1 actual %0d",
                                       $time, cycles));
    do begin
      got = a[2] ? fetch_rdata[63:32] : fetch_rdata[31:0];
      assert (got == mem_word(a))
        else stop_with_failure($sformatf("Error: %0t fetch_rdata expected %h actual %h",
                                         $time, mem_word(a), got));
      take         = ($urandom_range(3, 0) != 0);
      fetch_rready = take;
      @(posedge clk);
      #1;
    end while (!take);
    fetch_rready = 1'b0;
    assert (mem_requests == exp_mem)
      else stop_with_failure($sformatf("Error: %0t mem_arvalid requests expected %0d actual %0d",
                                       $time, exp_mem, mem_requests));
    assert (hit_count == exp_hits)
      else stop_with_failure($sformatf("Error: %0t hit_count expected %0d actual %0d",
                                       $time, exp_hits, hit_count));
    assert (miss_count == exp_misses)
      else stop_with_failure($sformatf("Error: %0t miss_count expected %0d actual %0d",
                                       $time, exp_misses, miss_count));
    if (in_cached_region(a)) begin
      model_valid[bank][idx] = 1'b1;
      model_tag[bank][idx]   = a[31:TAG_LSB];
    end
  endtask

  initial begin : stimulus
    logic [3:0] region;
    void'($urandom(27010));
    rstn          = 1'b0;
    fetch_arvalid = 1'b0;
    fetch_araddr  = '0;
    fetch_rready  = 1'b0;
    foreach (model_valid[b, i])
      model_valid[b][i] = 1'b0;
    // first touch, repeat, other bank, fast memory, then a tag conflict
    fetch_q = {32'h3000_0010, 32'h3000_0010, 32'h3000_0014, 32'h3000_0014,
               32'h1000_0020, 32'h1000_0020, 32'h3000_0050, 32'h3000_0014,
               32'h3000_0010, 32'h3000_0014, 32'h3000_0050, 32'h3000_0010};
    repeat (RANDOM_FETCHES) begin
      case ($urandom_range(2, 0))
        0: region = 4'h0;
        1: region = 4'h3;
        default: region = 4'h8;
      endcase
      fetch_q.push_back({region, 18'd0, 8'($urandom_range(255, 0)), 2'b00});
    end
    queue_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    foreach (fetch_q[k])
      run_fetch(fetch_q[k]);
    repeat (4) @(posedge clk);
    if (uut.u_checks.failed) begin
      stop_with_failure("a bound assertion on the DUT ports failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (uut.u_checks.failed)
      stop_with_failure("a bound assertion on the DUT ports failed");
  end

  initial begin : watchdog
    wait (queue_ready);
    #(CLK_PERIOD * CYCLES_PER_FETCH * fetch_q.size());
    stop_with_failure("the run hung, a fetch never completed");
  end

endmodule

/* flist.f */
src/icache_pkg.sv
src/fetch_bank_if.sv
src/refill_if.sv
src/fetch_router.sv
src/icache_bank.sv
src/refill_arbiter.sv
src/icache_top.sv
bench/tb_clock.sv
bench/icache_assertions.sv
bench/tb_icache.sv

/* src/fetch_bank_if.sv */
`timescale 1ns/100ps

interface fetch_bank_if import icache_pkg::*;;

  logic  req_valid;  // one-cycle request pulse
  addr_t req_addr;

  logic  resp_valid;
  logic  resp_ready;
  beat_t resp_data;

  // response transfer and its classification
  logic  done;
  logic  hit_event;
  logic  miss_event;

  modport router (
    output req_valid,
    output req_addr,
    output resp_ready,
    input  resp_valid,
    input  resp_data,
    input  done,
    input  hit_event,
    input  miss_event
  );

  modport bank (
    input  req_valid,
    input  req_addr,
    input  resp_ready,
    output resp_valid,
    output resp_data,
    output done,
    output hit_event,
    output miss_event
  );

endinterface

/* src/fetch_router.sv */
`timescale 1ns/100ps

module fetch_router import icache_pkg::*; #(
  parameter int NUM_BANKS = 2
) (
  input  logic         clk,
  input  logic         rstn,
  input  logic         fetch_arvalid,
  output logic         fetch_arready,
  input  addr_t        fetch_araddr,
  output logic         fetch_rvalid,
  input  logic         fetch_rready,
  output beat_t        fetch_rdata,
  output logic  [31:0] hit_count,
  output logic  [31:0] miss_count,
  fetch_bank_if.router banks [NUM_BANKS]
);

  localparam int BANK_W = $clog2(NUM_BANKS);

  logic [BANK_W-1:0] sel;
  logic              req_valid;
  addr_t             req_addr;

  logic [NUM_BANKS-1:0] resp_valid_v;
  logic [NUM_BANKS-1:0] done_v;
  logic [NUM_BANKS-1:0] hit_v;
  logic [NUM_BANKS-1:0] miss_v;
  beat_t                resp_data_v [NUM_BANKS];

  logic accept;

  assign accept = fetch_arvalid & fetch_arready;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : bank_port
    assign banks[b].req_valid  = req_valid && (sel == BANK_W'(b));
    assign banks[b].req_addr   = req_addr;
    assign banks[b].resp_ready = fetch_rready && (sel == BANK_W'(b));
    assign resp_valid_v[b]     = banks[b].resp_valid;
    assign resp_data_v[b]      = banks[b].resp_data;
    assign done_v[b]           = banks[b].done;
    assign hit_v[b]            = banks[b].hit_event;
    assign miss_v[b]           = banks[b].miss_event;
  end

  // response passes straight through from the busy bank
  assign fetch_rvalid = resp_valid_v[sel];
  assign fetch_rdata  = resp_data_v[sel];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      fetch_arready <= 1'b1;
      req_valid     <= 1'b0;
      sel           <= '0;
      hit_count     <= '0;
      miss_count    <= '0;
    end else begin
      req_valid <= accept;  // banks sit in IDLE, one cycle is enough
      if (accept) begin
        sel           <= fetch_araddr[BYTE_OFF_W +: BANK_W];
        fetch_arready <= 1'b0;
      end else if (|done_v) begin
        fetch_arready <= 1'b1;
      end
      if (|hit_v)
        hit_count <= hit_count + 32'd1;
      if (|miss_v)
        miss_count <= miss_count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      req_addr <= fetch_araddr;
  end

endmodule

/* src/icache_bank.sv */
`timescale 1ns/100ps

module icache_bank import icache_pkg::*; #(
  parameter int INDEX_W   = 3,
  parameter int NUM_BANKS = 2
) (
  input  logic       clk,
  input  logic       rstn,
  fetch_bank_if.bank fb,
  refill_if.bank     rf
);

  localparam int BANK_W    = $clog2(NUM_BANKS);
  localparam int INDEX_LSB = BYTE_OFF_W + BANK_W;  // bank bits sit below the index
  localparam int TAG_LSB   = INDEX_LSB + INDEX_W;
  localparam int TAG_W     = ADDR_W - TAG_LSB;
  localparam int LINES     = 1 << INDEX_W;

  logic [LINES-1:0] line_valid;
  logic [TAG_W-1:0] line_tag [LINES];
  word_t            line_word [LINES];

  bank_state_e state;
  addr_t       addr_reg;
  logic        hit_reg;

  logic [INDEX_W-1:0] req_index;
  logic [TAG_W-1:0]   req_tag;
  logic               lookup_hit;
  logic [INDEX_W-1:0] fill_index;
  logic [TAG_W-1:0]   fill_tag;
  word_t              fill_word;
  logic               fill_take;

  assign req_index = fb.req_addr[INDEX_LSB +: INDEX_W];
  assign req_tag   = fb.req_addr[TAG_LSB +: TAG_W];

  // sram lines are never allocated, the cacheable check keeps that safe
  assign lookup_hit = line_valid[req_index] && (line_tag[req_index] == req_tag) &&
                      is_cacheable(fb.req_addr);

  assign fill_index = addr_reg[INDEX_LSB +: INDEX_W];
  assign fill_tag   = addr_reg[TAG_LSB +: TAG_W];
  assign fill_word  = addr_reg[BEAT_SEL_BIT] ? rf.fill_data[WORD_W +: WORD_W]
                                             : rf.fill_data[0 +: WORD_W];
  assign fill_take  = (state == REFILL) && rf.fill_valid;

  // memory sees the beat-aligned address
  assign rf.miss_addr = {addr_reg[ADDR_W-1:BEAT_SEL_BIT+1], {(BEAT_SEL_BIT+1){1'b0}}};

  assign fb.done       = fb.resp_valid & fb.resp_ready;
  assign fb.hit_event  = fb.done & hit_reg;
  assign fb.miss_event = fb.done & ~hit_reg;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state         <= IDLE;
      line_valid    <= '0;
      fb.resp_valid <= 1'b0;
      rf.miss_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (fb.req_valid) begin
            if (lookup_hit) begin
              fb.resp_valid <= 1'b1;
              state         <= RESPOND;
            end else begin
              rf.miss_valid <= 1'b1;
              state         <= REFILL;
            end
          end
        end
        REFILL: begin
          if (rf.fill_valid) begin
            rf.miss_valid <= 1'b0;
            fb.resp_valid <= 1'b1;
            state         <= RESPOND;
            if (is_cacheable(addr_reg))
              line_valid[fill_index] <= 1'b1;
          end
        end
        RESPOND: begin
          if (fb.done) begin
            fb.resp_valid <= 1'b0;
            state         <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == IDLE) && fb.req_valid) begin
      addr_reg     <= fb.req_addr;
      hit_reg      <= lookup_hit;
      fb.resp_data <= {2{line_word[req_index]}};  // same word in both halves
    end
    if (fill_take) begin
      fb.resp_data <= rf.fill_data;  // full beat back to the fetch side
      if (is_cacheable(addr_reg)) begin
        line_tag[fill_index]  <= fill_tag;
        line_word[fill_index] <= fill_word;
      end
    end
  end

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

  localparam int ADDR_W       = 32;
  localparam int WORD_W       = 32;
  localparam int BEAT_W       = 64;
  localparam int BYTE_OFF_W   = 2;  // byte lanes inside a word
  localparam int BEAT_SEL_BIT = 2;  // picks the beat half
  localparam int REGION_W     = 4;

  // top nibble at or above this is flash/sdram, below is fast sram
  localparam logic [REGION_W-1:0] CACHEABLE_BASE = 4'd3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BEAT_W-1:0] beat_t;  // upper half holds the bit-2-set word

  typedef enum logic [1:0] {
    IDLE,
    RESPOND,
    REFILL
  } bank_state_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ADDR,
    ARB_DATA
  } arb_state_e;

  function automatic logic is_cacheable(addr_t a);
    return a[ADDR_W-1 -: REGION_W] >= CACHEABLE_BASE;
  endfunction

endpackage

/* src/icache_top.sv */
`timescale 1ns/100ps

module icache_top import icache_pkg::*; #(
  parameter int NUM_BANKS = 2,  // power of two
  parameter int INDEX_W   = 3
) (
  input  logic        clk,
  input  logic        rstn,

  input  logic        fetch_arvalid,
  output logic        fetch_arready,
  input  addr_t       fetch_araddr,
  output logic        fetch_rvalid,
  input  logic        fetch_rready,
  output beat_t       fetch_rdata,

  output logic        mem_arvalid,
  input  logic        mem_arready,
  output addr_t       mem_araddr,
  input  logic        mem_rvalid,
  output logic        mem_rready,
  input  beat_t       mem_rdata,

  output logic [31:0] hit_count,
  output logic [31:0] miss_count
);

  fetch_bank_if fbs [NUM_BANKS] ();
  refill_if     rfs [NUM_BANKS] ();

  fetch_router #(
    .NUM_BANKS (NUM_BANKS)
  ) u_router (
    .clk           (clk),
    .rstn          (rstn),
    .fetch_arvalid (fetch_arvalid),
    .fetch_arready (fetch_arready),
    .fetch_araddr  (fetch_araddr),
    .fetch_rvalid  (fetch_rvalid),
    .fetch_rready  (fetch_rready),
    .fetch_rdata   (fetch_rdata),
    .hit_count     (hit_count),
    .miss_count    (miss_count),
    .banks         (fbs)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : bank_gen
    icache_bank #(
      .INDEX_W   (INDEX_W),
      .NUM_BANKS (NUM_BANKS)
    ) u_bank (
      .clk  (clk),
      .rstn (rstn),
      .fb   (fbs[i]),
      .rf   (rfs[i])
    );
  end

  refill_arbiter #(
    .NUM_BANKS (NUM_BANKS)
  ) u_arbiter (
    .clk         (clk),
    .rstn        (rstn),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_araddr  (mem_araddr),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready),
    .mem_rdata   (mem_rdata),
    .rfs         (rfs)
  );

endmodule

/* src/refill_arbiter.sv */
`timescale 1ns/100ps

module refill_arbiter import icache_pkg::*; #(
  parameter int NUM_BANKS = 2
) (
  input  logic      clk,
  input  logic      rstn,
  output logic      mem_arvalid,
  input  logic      mem_arready,
  output addr_t     mem_araddr,
  input  logic      mem_rvalid,
  output logic      mem_rready,
  input  beat_t     mem_rdata,
  refill_if.arbiter rfs [NUM_BANKS]
);

  localparam int BANK_W = $clog2(NUM_BANKS);

  arb_state_e state;

  logic [BANK_W-1:0]    grant;
  logic [BANK_W-1:0]    pick;
  logic [BANK_W-1:0]    cur;
  logic [NUM_BANKS-1:0] req_v;
  logic [NUM_BANKS-1:0] fill_v;
  addr_t                miss_addr_v [NUM_BANKS];
  beat_t                fill_data;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : bank_port
    // a bank being filled still shows miss_valid for this cycle
    assign req_v[b]          = rfs[b].miss_valid & ~fill_v[b];
    assign miss_addr_v[b]    = rfs[b].miss_addr;
    assign rfs[b].fill_valid = fill_v[b];
    assign rfs[b].fill_data  = fill_data;
  end

  always_comb begin
    pick = '0;
    for (int b = NUM_BANKS - 1; b >= 0; b--) begin
      if (req_v[b])
        pick = BANK_W'(b);  // lowest index wins
    end
  end

  assign cur         = (state == ARB_IDLE) ? pick : grant;
  assign mem_arvalid = ((state == ARB_IDLE) && (|req_v)) || (state == ARB_ADDR);
  assign mem_araddr  = miss_addr_v[cur];
  assign mem_rready  = 1'b1;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state  <= ARB_IDLE;
      grant  <= '0;
      fill_v <= '0;
    end else begin
      fill_v <= '0;
      case (state)
        ARB_IDLE: begin
          if (|req_v) begin
            grant <= pick;  // lock so a stalled address holds
            state <= mem_arready ? ARB_DATA : ARB_ADDR;
          end
        end
        ARB_ADDR: if (mem_arready) state <= ARB_DATA;
        ARB_DATA: begin
          if (mem_rvalid) begin
            fill_v[grant] <= 1'b1;
            state         <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ARB_DATA) && mem_rvalid)
      fill_data <= mem_rdata;
  end

endmodule

/* src/refill_if.sv */
`timescale 1ns/100ps

interface refill_if import icache_pkg::*;;

  // held by the bank until fill_valid
  logic  miss_valid;
  addr_t miss_addr;

  logic  fill_valid;  // single cycle
  beat_t fill_data;

  modport bank (
    output miss_valid,
    output miss_addr,
    input  fill_valid,
    input  fill_data
  );

  modport arbiter (
    input  miss_valid,
    input  miss_addr,
    output fill_valid,
    output fill_data
  );

endinterface
